// File: verilog/uartPkg.sv
// Shared UART widths, frame constants and structs that the RTL and the checker use by scoped name
package uartPkg;

  //////////////////////////////////////////////////
  // Divisor constants
  //////////////////////////////////////////////////

  // Default bit width of the clocks-per-bit divisor
  localparam int defaultDivWidth = 12;

  // Smallest divisor the configuration block accepts
  // Half a bit must still be at least two cycles
  localparam int minClksPerBit = 4;

  //////////////////////////////////////////////////
  // Frame constants
  //////////////////////////////////////////////////

  // 8N1 framing
  localparam int dataBits = 8;
  localparam int stopBits = 1;

  // Start bit plus data bits plus stop bit
  localparam int frameBits = 1 + dataBits + stopBits;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  // Received byte with its stop-bit status
  typedef struct packed {
    logic [dataBits-1:0] data;
    logic                frameError;
  } rxFrame;

  // Busy levels of both engines, read by the configuration block
  typedef struct packed {
    logic txBusy;
    logic rxBusy;
  } linkStatus;

endpackage

// File: verilog/uartConfig.sv
// Clocks-per-bit register block, takes host writes and commits them while both UART engines are idle
module uartConfig #(
  parameter int divWidth        = uartPkg::defaultDivWidth,
  parameter int resetClksPerBit = 8
) (
  input  logic                  r_Clock,
  input  logic                  i_reset,
  input  logic                  i_cfgWrite,
  input  logic [divWidth-1:0]   i_cfgClksPerBit,
  input  uartPkg::linkStatus    i_status,
  output logic [divWidth-1:0]   o_clksPerBit
);

  // Floor and reset value at divisor width
  localparam logic [divWidth-1:0] minDiv   = divWidth'(uartPkg::minClksPerBit);
  localparam logic [divWidth-1:0] resetDiv = divWidth'(resetClksPerBit);

  logic [divWidth-1:0] clampedDiv;
  logic [divWidth-1:0] pendingDiv;
  logic                pendingValid;
  logic [divWidth-1:0] nextPendingDiv;
  logic                nextPendingValid;
  logic                linkIdle;

  // Writes below the floor are raised to it
  assign clampedDiv = (i_cfgClksPerBit < minDiv) ? minDiv : i_cfgClksPerBit;

  // A write in this cycle overrides any older pending value
  assign nextPendingDiv   = i_cfgWrite ? clampedDiv : pendingDiv;
  assign nextPendingValid = i_cfgWrite | pendingValid;

  // Commit window, no frame in progress on either side
  assign linkIdle = !i_status.txBusy && !i_status.rxBusy;

  // Pending value, only meaningful while pendingValid is set
  always_ff @(posedge r_Clock)
  begin
    if (i_cfgWrite)
    begin
      pendingDiv <= clampedDiv;
    end
  end

  // Active divisor and pending flag
  // An idle link commits in the same edge as the write strobe
  always_ff @(posedge r_Clock)
  begin
    if (i_reset)
    begin
      o_clksPerBit <= resetDiv;
      pendingValid <= 1'b0;
    end
    else if (nextPendingValid && linkIdle)
    begin
      o_clksPerBit <= nextPendingDiv;
      pendingValid <= 1'b0;
    end
    else
    begin
      pendingValid <= nextPendingValid;
    end
  end

endmodule

// File: verilog/uartTx.sv
// UART transmit engine, sends one 8N1 frame LSB first after a start strobe at the active divisor
module uartTx #(
  parameter int divWidth = uartPkg::defaultDivWidth
) (
  input  logic                r_Clock,
  input  logic                i_reset,
  input  logic [divWidth-1:0] i_clksPerBit,
  input  logic                i_txStart,
  input  logic [7:0]          i_txByte,
  output logic                o_txSerial,
  output logic                o_txActive,
  output logic                o_txDone,
  output logic                o_busy
);

  // Bit index runs over the whole frame, start bit is index 0
  localparam int bitIdxWidth = $clog2(uartPkg::frameBits);
  localparam logic [bitIdxWidth-1:0] lastDataIdx = bitIdxWidth'(uartPkg::frameBits - 2);

  typedef enum logic [2:0] {
    txIdle,
    txStartBit,
    txDataBits,
    txStopBit,
    txCleanup
  } txState;

  txState                 state;
  logic [divWidth-1:0]    clkCount;
  logic [bitIdxWidth-1:0] bitIdx;
  logic [7:0]             txShift;
  logic [divWidth-1:0]    lastCount;
  logic                   bitEnd;

  // Last cycle of the current bit
  assign lastCount = i_clksPerBit - divWidth'(1);
  assign bitEnd    = (clkCount == lastCount);

  // Status mirror of the active level
  assign o_busy = o_txActive;

  //////////////////////////////////////////////////
  // Frame sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge r_Clock)
  begin
    if (i_reset)
    begin
      state      <= txIdle;
      clkCount   <= '0;
      bitIdx     <= '0;
      o_txSerial <= 1'b1;
      o_txActive <= 1'b0;
      o_txDone   <= 1'b0;
    end
    else
    begin
      // Done is a single-cycle pulse
      o_txDone <= 1'b0;
      case (state)
        // Cleanup behaves as idle so a strobe right after done is taken
        txIdle, txCleanup:
        begin
          state <= txIdle;
          if (i_txStart)
          begin
            state      <= txStartBit;
            clkCount   <= '0;
            bitIdx     <= '0;
            txShift    <= i_txByte;
            o_txSerial <= 1'b0;
            o_txActive <= 1'b1;
          end
        end
        txStartBit, txDataBits:
        begin
          if (bitEnd)
          begin
            clkCount <= '0;
            bitIdx   <= bitIdx + 1'b1;
            if (state == txDataBits && bitIdx == lastDataIdx)
            begin
              // Eighth data bit finished, stop bit is high
              state      <= txStopBit;
              o_txSerial <= 1'b1;
            end
            else
            begin
              // Next data bit, LSB first
              state      <= txDataBits;
              o_txSerial <= txShift[0];
              txShift    <= txShift >> 1;
            end
          end
          else
          begin
            clkCount <= clkCount + 1'b1;
          end
        end
        txStopBit:
        begin
          if (bitEnd)
          begin
            state      <= txCleanup;
            clkCount   <= '0;
            o_txActive <= 1'b0;
            o_txDone   <= 1'b1;
          end
          else
          begin
            clkCount <= clkCount + 1'b1;
          end
        end
        default:
        begin
          state <= txIdle;
        end
      endcase
    end
  end

endmodule

// File: verilog/uartRx.sv
// UART receive engine, recovers 8N1 frames from the serial line and flags a low stop bit
module uartRx #(
  parameter int divWidth = uartPkg::defaultDivWidth
) (
  input  logic                r_Clock,
  input  logic                i_reset,
  input  logic [divWidth-1:0] i_clksPerBit,
  input  logic                i_rxSerial,
  output logic                o_rxValid,
  output uartPkg::rxFrame     o_rxFrame,
  output logic                o_busy
);

  // Bit index runs over the whole frame, start bit is index 0
  localparam int bitIdxWidth = $clog2(uartPkg::frameBits);
  localparam logic [bitIdxWidth-1:0] lastDataIdx = bitIdxWidth'(uartPkg::frameBits - 2);

  typedef enum logic [2:0] {
    rxIdle,
    rxStartBit,
    rxDataBits,
    rxStopBit,
    rxCleanup
  } rxState;

  rxState                 state;
  logic                   rxMeta;
  logic                   rxSync;
  logic [divWidth-1:0]    clkCount;
  logic [bitIdxWidth-1:0] bitIdx;
  logic [7:0]             rxShift;
  logic [divWidth-1:0]    lastCount;
  logic [divWidth-1:0]    halfCount;

  // Full-bit and half-bit sample points
  assign lastCount = i_clksPerBit - divWidth'(1);
  assign halfCount = (i_clksPerBit >> 1) - divWidth'(1);

  //////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////

  // Two flops, both preset to the idle line level
  always_ff @(posedge r_Clock)
  begin
    if (i_reset)
    begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end
    else
    begin
      rxMeta <= i_rxSerial;
      rxSync <= rxMeta;
    end
  end

  //////////////////////////////////////////////////
  // Frame sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge r_Clock)
  begin
    if (i_reset)
    begin
      state     <= rxIdle;
      clkCount  <= '0;
      bitIdx    <= '0;
      o_rxValid <= 1'b0;
      o_busy    <= 1'b0;
    end
    else
    begin
      // Valid is a single-cycle pulse
      o_rxValid <= 1'b0;
      case (state)
        rxIdle:
        begin
          // Falling edge on the line opens a frame
          if (!rxSync)
          begin
            state    <= rxStartBit;
            clkCount <= '0;
            bitIdx   <= '0;
            o_busy   <= 1'b1;
          end
        end
        rxStartBit:
        begin
          if (clkCount == halfCount)
          begin
            clkCount <= '0;
            if (!rxSync)
            begin
              // Start bit confirmed at its middle
              state  <= rxDataBits;
              bitIdx <= bitIdx + 1'b1;
            end
            else
            begin
              // Glitch, line back high
              state  <= rxIdle;
              o_busy <= 1'b0;
            end
          end
          else
          begin
            clkCount <= clkCount + 1'b1;
          end
        end
        rxDataBits:
        begin
          if (clkCount == lastCount)
          begin
            // Middle of a data bit, shift in LSB first
            clkCount <= '0;
            bitIdx   <= bitIdx + 1'b1;
            rxShift  <= {rxSync, rxShift[7:1]};
            if (bitIdx == lastDataIdx)
            begin
              state <= rxStopBit;
            end
          end
          else
          begin
            clkCount <= clkCount + 1'b1;
          end
        end
        rxStopBit:
        begin
          if (clkCount == lastCount)
          begin
            // Middle of the stop bit, low here is a framing error
            state     <= rxCleanup;
            clkCount  <= '0;
            o_rxFrame <= '{data: rxShift, frameError: !rxSync};
            o_rxValid <= 1'b1;
            o_busy    <= 1'b0;
          end
          else
          begin
            clkCount <= clkCount + 1'b1;
          end
        end
        rxCleanup:
        begin
          // Hold off until the line is high so a low stop bit is not a new start
          if (rxSync)
          begin
            state <= rxIdle;
          end
        end
        default:
        begin
          state <= rxIdle;
        end
      endcase
    end
  end

endmodule

// File: verilog/uartLink.sv
// UART link top level, joins the divisor register with the transmit and receive engines
module uartLink #(
  parameter int divWidth        = uartPkg::defaultDivWidth,
  parameter int resetClksPerBit = 8
) (
  input  logic                r_Clock,
  input  logic                i_reset,
  // Configuration
  input  logic                i_cfgWrite,
  input  logic [divWidth-1:0] i_cfgClksPerBit,
  // Transmit side
  input  logic                i_txStart,
  input  logic [7:0]          i_txByte,
  output logic                o_txSerial,
  output logic                o_txActive,
  output logic                o_txDone,
  // Receive side
  input  logic                i_rxSerial,
  output logic                o_rxValid,
  output uartPkg::rxFrame     o_rxFrame,
  // Active divisor readback
  output logic [divWidth-1:0] o_clksPerBit
);

  logic               txBusy;
  logic               rxBusy;
  uartPkg::linkStatus status;

  // Busy levels gathered for the commit check
  assign status = '{txBusy: txBusy, rxBusy: rxBusy};

  //////////////////////////////////////////////////
  // Divisor register
  //////////////////////////////////////////////////

  uartConfig #(
    .divWidth        (divWidth),
    .resetClksPerBit (resetClksPerBit)
  ) u_config (
    .r_Clock         (r_Clock),
    .i_reset         (i_reset),
    .i_cfgWrite      (i_cfgWrite),
    .i_cfgClksPerBit (i_cfgClksPerBit),
    .i_status        (status),
    .o_clksPerBit    (o_clksPerBit)
  );

  //////////////////////////////////////////////////
  // Engines
  //////////////////////////////////////////////////

  // Both engines run from the same committed divisor
  uartTx #(
    .divWidth     (divWidth)
  ) u_tx (
    .r_Clock      (r_Clock),
    .i_reset      (i_reset),
    .i_clksPerBit (o_clksPerBit),
    .i_txStart    (i_txStart),
    .i_txByte     (i_txByte),
    .o_txSerial   (o_txSerial),
    .o_txActive   (o_txActive),
    .o_txDone     (o_txDone),
    .o_busy       (txBusy)
  );

  uartRx #(
    .divWidth     (divWidth)
  ) u_rx (
    .r_Clock      (r_Clock),
    .i_reset      (i_reset),
    .i_clksPerBit (o_clksPerBit),
    .i_rxSerial   (i_rxSerial),
    .o_rxValid    (o_rxValid),
    .o_rxFrame    (o_rxFrame),
    .o_busy       (rxBusy)
  );

endmodule

// File: tests/uartLinkChecker.sv
// Concurrent assertions on uartLink pulses, idle line level and divisor range, bound to the top level
module uartLinkChecker #(
  parameter int divWidth = uartPkg::defaultDivWidth
) (
  input logic                r_Clock,
  input logic                i_reset,
  input logic                i_txSerial,
  input logic                i_txActive,
  input logic                i_txDone,
  input logic                i_rxValid,
  input logic [divWidth-1:0] i_clksPerBit
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read by the testbench at the end of the run
  int assertFails = 0;

  // Done and valid are single-cycle pulses
  txDonePulse: assert property (@(posedge r_Clock) disable iff (i_reset)
    !(i_txDone && $past(i_txDone)))
    else
    begin
      assertFails++;
      $error("o_txDone high on two consecutive cycles");
    end

  rxValidPulse: assert property (@(posedge r_Clock) disable iff (i_reset)
    !(i_rxValid && $past(i_rxValid)))
    else
    begin
      assertFails++;
      $error("o_rxValid high on two consecutive cycles");
    end

  // Line idles high outside a frame
  idleLineHigh: assert property (@(posedge r_Clock) disable iff (i_reset)
    (i_txActive || i_txSerial))
    else
    begin
      assertFails++;
      $error("o_txSerial low while o_txActive is low");
    end

  // Clamp on writes keeps the divisor at or above the floor
  divisorFloor: assert property (@(posedge r_Clock) disable iff (i_reset)
    (i_clksPerBit >= divWidth'(uartPkg::minClksPerBit)))
    else
    begin
      assertFails++;
      $error("o_clksPerBit below the minimum divisor");
    end

endmodule

bind uartLink uartLinkChecker #(
  .divWidth     (divWidth)
) u_checker (
  .r_Clock      (r_Clock),
  .i_reset      (i_reset),
  .i_txSerial   (o_txSerial),
  .i_txActive   (o_txActive),
  .i_txDone     (o_txDone),
  .i_rxValid    (o_rxValid),
  .i_clksPerBit (o_clksPerBit)
);

// File: tests/uartLinkTb.sv
// Table-driven testbench for uartLink that runs loopback and bit-banged frames and checks data and timing
module uartLinkTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int divWidth = uartPkg::defaultDivWidth;
  localparam int resetDiv = 8;

  // Row modes
  localparam logic [2:0] modeLoop        = 3'd0;
  localparam logic [2:0] modeGood        = 3'd1;
  localparam logic [2:0] modeBadStop     = 3'd2;
  localparam logic [2:0] modeDeferred    = 3'd3;
  localparam logic [2:0] modeDoubleStart = 3'd4;

  // One stimulus row per test with its name kept in a parallel queue
  typedef struct packed {
    logic [divWidth-1:0] div;
    logic [7:0]          txByte;
    logic [2:0]          mode;
    logic [7:0]          expByte;
    logic                expErr;
  } stimRow;

  logic                r_Clock;
  logic                i_reset;
  logic                i_cfgWrite;
  logic [divWidth-1:0] i_cfgClksPerBit;
  logic                i_txStart;
  logic [7:0]          i_txByte;
  logic                rxLine;
  logic                benchSerial;
  logic                loopSel;
  logic                o_txSerial;
  logic                o_txActive;
  logic                o_txDone;
  logic                o_rxValid;
  uartPkg::rxFrame     o_rxFrame;
  logic [divWidth-1:0] o_clksPerBit;

  stimRow rows[$];
  string  names[$];
  int     errors;
  int     seed;
  int     activeDiv;
  int     rndWord;
  int     idx;

  // Loopback or bench-driven serial line
  assign rxLine = loopSel ? o_txSerial : benchSerial;

  uartLink #(
    .divWidth        (divWidth),
    .resetClksPerBit (resetDiv)
  ) i_dut (
    .r_Clock         (r_Clock),
    .i_reset         (i_reset),
    .i_cfgWrite      (i_cfgWrite),
    .i_cfgClksPerBit (i_cfgClksPerBit),
    .i_txStart       (i_txStart),
    .i_txByte        (i_txByte),
    .o_txSerial      (o_txSerial),
    .o_txActive      (o_txActive),
    .o_txDone        (o_txDone),
    .i_rxSerial      (rxLine),
    .o_rxValid       (o_rxValid),
    .o_rxFrame       (o_rxFrame),
    .o_clksPerBit    (o_clksPerBit)
  );

  // 20 ns period
  initial r_Clock = 1'b0;
  always #10 r_Clock = ~r_Clock;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Step to just after the next rising edge where inputs change and outputs are settled
  task automatic tick();
    @(posedge r_Clock);
    #2;
  endtask

  task automatic addRow(input string name, input int div, input logic [7:0] txByte,
                        input logic [2:0] mode, input logic [7:0] expByte, input logic expErr);
    names.push_back(name);
    rows.push_back('{div: divWidth'(div), txByte: txByte, mode: mode,
                     expByte: expByte, expErr: expErr});
  endtask

  // Idle write whose new value must read back one cycle after the strobe
  task automatic writeDivisor(input string name, input int value);
    int expDiv;
    expDiv = (value < uartPkg::minClksPerBit) ? uartPkg::minClksPerBit : value;
    i_cfgWrite      = 1'b1;
    i_cfgClksPerBit = divWidth'(value);
    tick();
    i_cfgWrite = 1'b0;
    if (o_clksPerBit !== divWidth'(expDiv))
    begin
      errors++;
      $display("FAIL %s clksPerBit expected %0d actual %0d", name, expDiv, o_clksPerBit);
    end
    activeDiv = expDiv;
  endtask

  // Send or drive one frame and wait for valid and done plus a quiet window with no extra pulses
  task automatic runFrame(input string name, input stimRow row);
    int              t;
    int              limit;
    int              tDone;
    int              doneCount;
    int              validCount;
    int              quiet;
    int              bitNo;
    int              newDiv;
    logic [9:0]      frame;
    logic            activeGap;
    logic            earlyCommit;
    uartPkg::rxFrame got;
    t           = 0;
    tDone       = -1;
    doneCount   = 0;
    validCount  = 0;
    quiet       = 0;
    activeGap   = 1'b0;
    earlyCommit = 1'b0;
    got         = '0;
    limit       = 20 * uartPkg::frameBits * activeDiv;
    // Start bit at index 0 and data LSB first below the stop bit
    frame   = {row.mode != modeBadStop, row.txByte, 1'b0};
    loopSel = (row.mode != modeGood) && (row.mode != modeBadStop);
    if (loopSel)
    begin
      i_txStart = 1'b1;
      i_txByte  = row.txByte;
    end
    else
    begin
      benchSerial = frame[0];
    end
    while ((validCount == 0 || (loopSel && doneCount == 0) || quiet < 12 * activeDiv)
           && t < limit)
    begin
      tick();
      t++;
      i_txStart  = 1'b0;
      i_cfgWrite = 1'b0;
      if (o_txDone)
      begin
        doneCount++;
        if (tDone < 0)
        begin
          tDone = t;
        end
      end
      if (o_rxValid)
      begin
        validCount++;
        got = o_rxFrame;
      end
      if (loopSel && tDone < 0 && !o_txActive)
      begin
        activeGap = 1'b1;
      end
      if (row.mode == modeDeferred && tDone < 0 && o_clksPerBit !== divWidth'(activeDiv))
      begin
        earlyCommit = 1'b1;
      end
      if (validCount > 0 && (!loopSel || doneCount > 0))
      begin
        quiet++;
      end
      // Bit-banged line goes high again after the stop bit
      bitNo       = t / activeDiv;
      benchSerial = (bitNo < uartPkg::frameBits) ? frame[bitNo] : 1'b1;
      // Mid-frame events for the deferred write and the ignored start
      if (row.mode == modeDoubleStart && t == 5 * activeDiv)
      begin
        i_txStart = 1'b1;
        i_txByte  = ~row.txByte;
      end
      if (row.mode == modeDeferred && t == 3 * activeDiv)
      begin
        i_cfgWrite      = 1'b1;
        i_cfgClksPerBit = row.div;
      end
    end
    if (validCount == 0 || (loopSel && doneCount == 0))
    begin
      errors++;
      $display("%s timed out waiting for the frame to finish", name);
    end
    else
    begin
      if (validCount != 1)
      begin
        errors++;
        $display("FAIL %s rxValid pulses expected 1 actual %0d", name, validCount);
      end
      if (got.data !== row.expByte)
      begin
        errors++;
        $display("FAIL %s data expected %02h actual %02h", name, row.expByte, got.data);
      end
      if (got.frameError !== row.expErr)
      begin
        errors++;
        $display("FAIL %s frameError expected %0b actual %0b", name, row.expErr,
                 got.frameError);
      end
      if (loopSel && doneCount != 1)
      begin
        errors++;
        $display("FAIL %s txDone pulses expected 1 actual %0d", name, doneCount);
      end
      if (loopSel && tDone != 10 * activeDiv + 1)
      begin
        errors++;
        $display("FAIL %s txDone cycle expected %0d actual %0d", name, 10 * activeDiv + 1,
                 tDone);
      end
      if (activeGap)
      begin
        errors++;
        $display("%s o_txActive dropped before the end of the frame", name);
      end
    end
    if (row.mode == modeDeferred)
    begin
      newDiv = (row.div < divWidth'(uartPkg::minClksPerBit)) ?
               uartPkg::minClksPerBit : int'(row.div);
      if (earlyCommit)
      begin
        errors++;
        $display("%s divisor changed while the frame was still being sent", name);
      end
      if (o_clksPerBit !== divWidth'(newDiv))
      begin
        errors++;
        $display("FAIL %s clksPerBit expected %0d actual %0d", name, newDiv, o_clksPerBit);
      end
      activeDiv = newDiv;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    i_reset         = 1'b1;
    i_cfgWrite      = 1'b0;
    i_cfgClksPerBit = '0;
    i_txStart       = 1'b0;
    i_txByte        = '0;
    benchSerial     = 1'b1;
    loopSel         = 1'b0;
    errors          = 0;
    seed            = 30656;
    activeDiv       = resetDiv;

    // Name, divisor, byte, mode, expected byte, expected frameError
    addRow("loop_reset_a5",  8, 8'hA5, modeLoop,        8'hA5, 1'b0);
    addRow("loop_reset_00",  8, 8'h00, modeLoop,        8'h00, 1'b0);
    addRow("loop_reset_ff",  8, 8'hFF, modeLoop,        8'hFF, 1'b0);
    addRow("div_odd_5",      5, 8'h3C, modeLoop,        8'h3C, 1'b0);
    addRow("div_floor_2",    2, 8'h96, modeLoop,        8'h96, 1'b0);
    addRow("div_wide_16",   16, 8'h5A, modeLoop,        8'h5A, 1'b0);
    addRow("deferred_prep",  8, 8'hC3, modeLoop,        8'hC3, 1'b0);
    addRow("deferred_write",12, 8'h81, modeDeferred,    8'h81, 1'b0);
    addRow("bad_stop",      12, 8'h6E, modeBadStop,     8'h6E, 1'b1);
    addRow("good_after_bad",12, 8'h91, modeGood,        8'h91, 1'b0);
    addRow("double_start",   8, 8'h4D, modeDoubleStart, 8'h4D, 1'b0);
    // Random loopback bytes expect the drawn byte back
    for (idx = 0; idx < 4; idx++)
    begin
      rndWord = $random(seed);
      addRow($sformatf("random_%0d", idx), 8, rndWord[7:0], modeLoop, rndWord[7:0], 1'b0);
    end

    repeat (16) @(posedge r_Clock);
    #2;
    i_reset = 1'b0;

    // State straight after reset
    if (o_txSerial !== 1'b1 || o_txActive !== 1'b0 || o_txDone !== 1'b0 || o_rxValid !== 1'b0)
    begin
      errors++;
      $display("Outputs not at their idle levels after reset");
    end
    if (o_clksPerBit !== divWidth'(resetDiv))
    begin
      errors++;
      $display("FAIL after_reset clksPerBit expected %0d actual %0d", resetDiv, o_clksPerBit);
    end

    for (idx = 0; idx < rows.size(); idx++)
    begin
      if (rows[idx].mode != modeDeferred)
      begin
        writeDivisor(names[idx], int'(rows[idx].div));
      end
      runFrame(names[idx], rows[idx]);
    end

    $display("Run complete, %0d check errors, %0d assertion failures", errors,
             i_dut.u_checker.assertFails);
    if (errors == 0 && i_dut.u_checker.assertFails == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: uartLink.f
verilog/uartPkg.sv
verilog/uartConfig.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/uartLink.sv
tests/uartLinkChecker.sv
tests/uartLinkTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f uartLink.f \
  --top-module uartLinkTb -o uartLinkSim || exit 1
simOut=$(./obj_dir/uartLinkSim 2>&1)
echo "$simOut"
echo "$simOut" | grep -q "TEST OK" && exit 0 || exit 1
